//--- filelist.f
icache_pkg.sv
icache_tag_store.sv
icache_data_bank.sv
icache_ctrl.sv
icache_word_select.sv
instruction_cache.sv
instruction_cache_props.sv
tb_instruction_cache.sv

//--- icache_ctrl.sv
// Instruction cache controller
// Sequences lookup, line request, refill, decode handshake and flush

`timescale 1ns/1ns

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int unsigned pc_width       = default_pc_width,
    parameter int unsigned line_word_bits = default_line_word_bits,
    parameter int unsigned num_lines      = default_num_lines,
    localparam int unsigned index_bits    = $clog2(num_lines)
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         flush_i,

    // Fetch side
    input  logic                         fe_valid_i,
    input  logic [pc_width-1:0]          fe_pc_i,
    output logic                         ic_ready_o,

    // Decode side
    input  logic                         dec_ready_i,
    output logic                         ic_valid_o,
    output logic [pc_width-1:0]          ic_pc_o,

    // Memory side
    input  logic                         mem_ready_i,
    input  logic                         mem_valid_i,
    output logic                         mem_req_o,
    output logic [pc_width-line_word_bits-1:0] mem_addr_o,

    // Tag store and banks
    input  logic                         hit_i,
    output logic                         lookup_o,
    output logic                         refill_o,
    output logic                         flush_apply_o,
    output logic [index_bits-1:0]        line_index_o,
    output logic [pc_width-1:0]          active_pc_o,
    output logic                         use_refill_o
);

    // ##########################################################
    // Signals
    // ##########################################################

    ctrl_state_e         state_q, state_d;

    // PC of the request in flight
    logic [pc_width-1:0] active_pc_q;

    // Flush seen but not yet applied
    logic                flush_q;

    // Handshakes
    logic                accept;
    logic                dec_done;

    // ##########################################################
    // Handshakes and strobes
    // ##########################################################

    // Word ready for decode: hit in lookup or refilled word
    assign ic_valid_o = (state_q == state_lookup && hit_i) || (state_q == state_wait_dec);
    assign dec_done   = ic_valid_o && dec_ready_i;

    // Safe points are idle or a finished decode transfer
    assign flush_apply_o = flush_q && (state_q == state_idle || dec_done);

    // No new request while a flush is pending
    assign ic_ready_o = (state_q == state_idle || dec_done) && !flush_q;
    assign accept     = ic_ready_o && fe_valid_i;

    // Tag and data read start on acceptance
    assign lookup_o = accept;

    // Miss: request the line of the active PC
    assign mem_req_o  = (state_q == state_lookup) && !hit_i;
    assign mem_addr_o = active_pc_q[pc_width-1:line_word_bits];

    // Refill writes tags and banks in the response cycle
    assign refill_o     = (state_q == state_wait_mem) && mem_valid_i;
    assign use_refill_o = (state_q == state_wait_dec);

    // Refill addresses the active line, lookup the incoming PC
    assign line_index_o = (state_q == state_wait_mem)
                        ? active_pc_q[line_word_bits +: index_bits]
                        : fe_pc_i[line_word_bits +: index_bits];

    assign ic_pc_o     = active_pc_q;
    assign active_pc_o = active_pc_q;

    // ##########################################################
    // Next state
    // ##########################################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            state_idle: begin
                // Pending flush keeps ready low, so no accept
                if (accept) begin
                    state_d = state_lookup;
                end
            end
            state_lookup: begin
                if (!hit_i) begin
                    // Leave once the memory took the request
                    if (mem_ready_i) begin
                        state_d = state_wait_mem;
                    end
                end else if (dec_done) begin
                    // Back to back fetch on a hit
                    state_d = accept ? state_lookup : state_idle;
                end
            end
            state_wait_mem: begin
                if (mem_valid_i) begin
                    state_d = state_wait_dec;
                end
            end
            state_wait_dec: begin
                if (dec_done) begin
                    state_d = accept ? state_lookup : state_idle;
                end
            end
            default: begin
                state_d = state_idle;
            end
        endcase
    end

    // ##########################################################
    // Registers
    // ##########################################################

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= state_idle;
            flush_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // A new pulse wins over a clear in the same cycle
            flush_q <= flush_i || (flush_q && !flush_apply_o);
        end
    end

    // Active PC, loaded on each accepted fetch
    always_ff @(posedge clk_i) begin
        if (accept) begin
            active_pc_q <= fe_pc_i;
        end
    end

endmodule : icache_ctrl

//--- icache_data_bank.sv
// Instruction cache data bank
// One instruction slot of every cacheline, single port, 1-cycle read

`timescale 1ns/1ns

module icache_data_bank
    import icache_pkg::*;
#(
    parameter int unsigned inst_width  = default_inst_width,
    parameter int unsigned num_lines   = default_num_lines,
    localparam int unsigned index_bits = $clog2(num_lines)
) (
    input  logic                  clk_i,
    // Read for a new fetch
    input  logic                  lookup_i,
    // Write the refilled slot
    input  logic                  refill_i,
    input  logic [index_bits-1:0] line_index_i,
    input  logic [inst_width-1:0] wdata_i,
    output logic [inst_width-1:0] rdata_o
);

    // Storage array
    logic [inst_width-1:0] mem [num_lines];

    // Single port, lookup and refill never overlap
    // Read data holds until the next lookup
    always_ff @(posedge clk_i) begin
        if (refill_i) begin
            mem[line_index_i] <= wdata_i;
        end else if (lookup_i) begin
            rdata_o <= mem[line_index_i];
        end
    end

endmodule : icache_data_bank

//--- icache_pkg.sv
// Instruction cache package
// Controller state encoding and default cache geometry

package icache_pkg;

    // ##########################################################
    // Controller states
    // ##########################################################

    typedef enum logic [1:0] {
        // Waiting for a fetch request
        state_idle     = 2'd0,
        // Tag and data read in flight, hit or miss decided here
        state_lookup   = 2'd1,
        // Line request sent, waiting for the refill
        state_wait_mem = 2'd2,
        // Refilled word held until the decoder takes it
        state_wait_dec = 2'd3
    } ctrl_state_e;

    // ##########################################################
    // Default geometry
    // ##########################################################

    // Program counter width
    localparam int unsigned default_pc_width       = 32;

    // Encoded instruction width
    localparam int unsigned default_inst_width     = 32;

    // Log2 of instructions per cacheline
    // Also sets the width of the memory response
    localparam int unsigned default_line_word_bits = 2;

    // Number of cachelines, power of two
    localparam int unsigned default_num_lines      = 8;

endpackage : icache_pkg

//--- icache_tag_store.sv
// Instruction cache tag store
// Tag memory with registered read, valid vector and hit compare

`timescale 1ns/1ns

module icache_tag_store
    import icache_pkg::*;
#(
    parameter int unsigned pc_width       = default_pc_width,
    parameter int unsigned line_word_bits = default_line_word_bits,
    parameter int unsigned num_lines      = default_num_lines,
    localparam int unsigned index_bits    = $clog2(num_lines),
    localparam int unsigned tag_bits      = pc_width - line_word_bits - index_bits
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    // Read request for a new fetch
    input  logic                  lookup_i,
    // Write the tag of the active PC
    input  logic                  refill_i,
    // Invalidate every line
    input  logic                  flush_apply_i,
    input  logic [index_bits-1:0] line_index_i,
    input  logic [pc_width-1:0]   active_pc_i,
    output logic                  hit_o
);

    // PC = {tag, index, word offset}
    logic [tag_bits-1:0]  active_tag;

    // Tag array, no reset needed since valid bits guard it
    logic [tag_bits-1:0]  tag_mem [num_lines];
    logic [tag_bits-1:0]  tag_rd_q;

    // One valid bit per line
    logic [num_lines-1:0] valid_q;
    logic                 valid_rd_q;

    assign active_tag = active_pc_i[pc_width-1 -: tag_bits];

    // Tag memory port
    // Read on lookup, write on refill, never both
    always_ff @(posedge clk_i) begin
        if (refill_i) begin
            tag_mem[line_index_i] <= active_tag;
        end
        if (lookup_i) begin
            tag_rd_q <= tag_mem[line_index_i];
        end
    end

    // Valid vector and its read register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q    <= '0;
            valid_rd_q <= 1'b0;
        end else begin
            if (flush_apply_i) begin
                valid_q <= '0;
            end else if (refill_i) begin
                valid_q[line_index_i] <= 1'b1;
            end
            // Sampled with the tag so both describe the same line
            if (lookup_i) begin
                valid_rd_q <= valid_q[line_index_i];
            end
        end
    end

    // Read data holds between lookups, so hit stays stable while stalled
    assign hit_o = valid_rd_q && (tag_rd_q == active_tag);

endmodule : icache_tag_store

//--- icache_word_select.sv
// Instruction cache word selector
// Captures the refill line and picks the word for the decoder

`timescale 1ns/1ns

module icache_word_select
    import icache_pkg::*;
#(
    parameter int unsigned pc_width       = default_pc_width,
    parameter int unsigned inst_width     = default_inst_width,
    parameter int unsigned line_word_bits = default_line_word_bits,
    localparam int unsigned line_width    = inst_width << line_word_bits
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    // Capture strobe, one cycle with the memory response
    input  logic                  refill_i,
    input  logic [line_width-1:0] refill_line_i,
    // Read data of all banks, slot k at k times inst_width
    input  logic [line_width-1:0] bank_rdata_i,
    // Take the word from the captured line
    input  logic                  use_refill_i,
    input  logic [pc_width-1:0]   active_pc_i,
    output logic [inst_width-1:0] ic_inst_o
);

    logic [line_width-1:0]     refill_line_q;
    logic [line_word_bits-1:0] word_offset;
    logic [line_width-1:0]     src_line;

    // Refill line register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            refill_line_q <= '0;
        end else if (refill_i) begin
            refill_line_q <= refill_line_i;
        end
    end

    // Slot from the low PC bits
    assign word_offset = active_pc_i[line_word_bits-1:0];

    // Miss path reads the captured line, hit path the banks
    assign src_line = use_refill_i ? refill_line_q : bank_rdata_i;

    assign ic_inst_o = src_line[word_offset*inst_width +: inst_width];

endmodule : icache_word_select

//--- instruction_cache.sv
// Direct mapped instruction cache
// Fetch requests in, instruction words out, whole lines refilled from memory

`timescale 1ns/1ns

module instruction_cache
    import icache_pkg::*;
#(
    parameter int unsigned pc_width       = default_pc_width,
    parameter int unsigned inst_width     = default_inst_width,
    parameter int unsigned line_word_bits = default_line_word_bits,
    parameter int unsigned num_lines      = default_num_lines,
    localparam int unsigned num_words     = 1 << line_word_bits,
    localparam int unsigned line_width    = num_words * inst_width,
    localparam int unsigned index_bits    = $clog2(num_lines)
) (
    input  logic                               clk_i,
    input  logic                               reset_i,
    input  logic                               flush_i,

    // Memory request
    input  logic                               mem_ready_i,
    output logic                               mem_req_o,
    output logic [pc_width-line_word_bits-1:0] mem_addr_o,

    // Memory response, whole line
    input  logic                               mem_valid_i,
    input  logic [line_width-1:0]              mem_data_i,

    // Fetcher
    output logic                               ic_ready_o,
    input  logic                               fe_valid_i,
    input  logic [pc_width-1:0]                fe_pc_i,

    // Decoder
    input  logic                               dec_ready_i,
    output logic                               ic_valid_o,
    output logic [pc_width-1:0]                ic_pc_o,
    output logic [inst_width-1:0]              ic_inst_o
);

    // Controller strobes
    logic                  lookup;
    logic                  refill;
    logic                  flush_apply;
    logic                  use_refill;
    logic                  hit;
    logic [index_bits-1:0] line_index;
    logic [pc_width-1:0]   active_pc;

    // All bank outputs side by side
    logic [line_width-1:0] bank_rdata;

    icache_ctrl #(
        .pc_width      (pc_width),
        .line_word_bits(line_word_bits),
        .num_lines     (num_lines)
    ) u_ctrl (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .fe_valid_i   (fe_valid_i),
        .fe_pc_i      (fe_pc_i),
        .ic_ready_o   (ic_ready_o),
        .dec_ready_i  (dec_ready_i),
        .ic_valid_o   (ic_valid_o),
        .ic_pc_o      (ic_pc_o),
        .mem_ready_i  (mem_ready_i),
        .mem_valid_i  (mem_valid_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .hit_i        (hit),
        .lookup_o     (lookup),
        .refill_o     (refill),
        .flush_apply_o(flush_apply),
        .line_index_o (line_index),
        .active_pc_o  (active_pc),
        .use_refill_o (use_refill)
    );

    icache_tag_store #(
        .pc_width      (pc_width),
        .line_word_bits(line_word_bits),
        .num_lines     (num_lines)
    ) u_tag_store (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .lookup_i     (lookup),
        .refill_i     (refill),
        .flush_apply_i(flush_apply),
        .line_index_i (line_index),
        .active_pc_i  (active_pc),
        .hit_o        (hit)
    );

    // One bank per instruction slot of a line
    for (genvar k = 0; k < num_words; k++) begin : g_bank
        icache_data_bank #(
            .inst_width(inst_width),
            .num_lines (num_lines)
        ) u_bank (
            .clk_i       (clk_i),
            .lookup_i    (lookup),
            .refill_i    (refill),
            .line_index_i(line_index),
            .wdata_i     (mem_data_i[k*inst_width +: inst_width]),
            .rdata_o     (bank_rdata[k*inst_width +: inst_width])
        );
    end

    icache_word_select #(
        .pc_width      (pc_width),
        .inst_width    (inst_width),
        .line_word_bits(line_word_bits)
    ) u_word_select (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .refill_i     (refill),
        .refill_line_i(mem_data_i),
        .bank_rdata_i (bank_rdata),
        .use_refill_i (use_refill),
        .active_pc_i  (active_pc),
        .ic_inst_o    (ic_inst_o)
    );

endmodule : instruction_cache

//--- instruction_cache_props.sv
// Instruction cache protocol properties
// Bound into the controller, checks the memory and decode strobes

`timescale 1ns/1ns

module instruction_cache_props
    import icache_pkg::*;
#(
    parameter int unsigned addr_width = 30
) (
    input logic                  clk_i,
    input logic                  reset_i,
    input ctrl_state_e           state_q,
    input logic                  mem_valid_i,
    input logic                  mem_req_o,
    input logic                  mem_ready_i,
    input logic [addr_width-1:0] mem_addr_o,
    input logic                  ic_valid_o,
    input logic                  dec_ready_i
);

    // Responses only while a refill is awaited
    a_resp_state: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_valid_i |-> state_q == state_wait_mem) else $error("mem_valid_i outside wait_mem");

    // Request and line address hold until taken
    a_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_req_o && !mem_ready_i |=> mem_req_o && $stable(mem_addr_o))
        else $error("mem_req_o or mem_addr_o changed before mem_ready_i");

    // Decode valid holds until taken
    a_valid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        ic_valid_o && !dec_ready_i |=> ic_valid_o) else $error("ic_valid_o dropped early");

endmodule : instruction_cache_props

bind icache_ctrl instruction_cache_props #(
    .addr_width(pc_width - line_word_bits)
) props0 (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .state_q    (state_q),
    .mem_valid_i(mem_valid_i),
    .mem_req_o  (mem_req_o),
    .mem_ready_i(mem_ready_i),
    .mem_addr_o (mem_addr_o),
    .ic_valid_o (ic_valid_o),
    .dec_ready_i(dec_ready_i)
);

//--- run_sim.sh
#!/bin/bash
# Build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_instruction_cache \
    -f filelist.f -o sim_icache \
    && ./obj_dir/sim_icache > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0

//--- tb_instruction_cache.sv
// Instruction cache testbench
// Memory model, residency model and reference check of every decode transfer

`timescale 1ns/1ns

module tb_instruction_cache
    import icache_pkg::*;
();

    localparam int unsigned pw  = default_pc_width;
    localparam int unsigned iw  = default_inst_width;
    localparam int unsigned lwb = default_line_word_bits;
    localparam int unsigned nl  = default_num_lines;
    localparam int unsigned ib  = $clog2(nl);
    localparam int unsigned lw  = iw << lwb;
    // 1 cold + 4 resident + 3 conflict + 3 flush + 40 random
    localparam int num_fetches   = 51;
    localparam int timeout_limit = num_fetches * 20;

    // DUT inputs, all start in a known state
    logic              clk_i       = 1'b0;
    logic              reset_i     = 1'b1;
    logic              flush_i     = 1'b0;
    logic              fe_valid_i  = 1'b0;
    logic [pw-1:0]     fe_pc_i     = '0;
    logic              dec_ready_i = 1'b1;
    logic              mem_ready_i = 1'b1;
    logic              mem_valid_i = 1'b0;
    logic [lw-1:0]     mem_data_i  = '0;
    logic              ic_ready_o, ic_valid_o, mem_req_o;
    logic [pw-1:0]     ic_pc_o;
    logic [iw-1:0]     ic_inst_o;
    logic [pw-lwb-1:0] mem_addr_o;

    // ############################################################
    // Bookkeeping
    // ############################################################

    int          cycle = 0, err_value = 0, err_proto = 0;
    int          req_count = 0, xfer_count = 0, accept_cyc = 0, valid_cyc = 0;
    int          resp_wait = 0;
    int unsigned lcg_state = 32'h31c9;
    string       cur_test = "reset";
    logic [pw-1:0]     cur_pc = '0, held_pc = '0;
    logic [iw-1:0]     held_inst = '0;
    logic [pw-lwb-1:0] take_addr = '0, resp_addr = '0, held_addr = '0;
    logic        take_q = 1'b0, mreq_hold = 1'b0, hold_q = 1'b0, valid_q = 1'b0;
    logic        stall_mode = 1'b0;
    // Fetch accepted and not yet handed to decode
    logic        flight_q = 1'b0;
    // Resident lines as the testbench sees them
    logic        res_valid [nl];
    logic [pw-1:0] res_tag [nl];

    instruction_cache dut0 (.*);

    function automatic int unsigned rand_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    // Expected word, mixes the line address with the slot number
    function automatic logic [iw-1:0] ref_inst(input logic [pw-1:0] pc);
        logic [pw-1:0] la;
        la = pc >> lwb;
        return iw'((la * 32'h9e3779b9) ^ (32'(pc[lwb-1:0]) * 32'h01000193) ^ 32'hc3a50f1e);
    endfunction

    function automatic logic [lw-1:0] build_line(input logic [pw-lwb-1:0] addr);
        logic [lw-1:0] line;
        for (int k = 0; k < (1 << lwb); k++) begin
            line[k*iw +: iw] = ref_inst({addr, lwb'(k)});
        end
        return line;
    endfunction

    // ############################################################
    // Clock, timeout and memory model
    // ############################################################

    initial begin
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle = cycle + 1;
        if (cycle > timeout_limit) begin
            $display("Timeout after %0d cycles in %s, a handshake never completed",
                     cycle, cur_test);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Sample the request port where it is stable
    always @(negedge clk_i) begin
        if (mreq_hold) begin
            assert (mem_req_o && mem_addr_o == held_addr) else begin
                err_proto++;
                $display("%s: memory request dropped or changed before it was taken", cur_test);
            end
        end
        if (mem_req_o && mem_ready_i) begin
            take_q    = 1'b1;
            take_addr = mem_addr_o;
            req_count++;
            assert (mem_addr_o == (cur_pc >> lwb)) else begin
                err_value++;
                $display("ERR %s mem_addr exp=%h act=%h", cur_test, cur_pc >> lwb, mem_addr_o);
            end
        end
        mreq_hold = mem_req_o && !mem_ready_i;
        held_addr = mem_addr_o;
    end

    // Response 1 to 4 cycles after the take, random stalls on both ready inputs
    always @(posedge clk_i) begin
        int unsigned r;
        mem_valid_i <= 1'b0;
        if (resp_wait > 0) begin
            resp_wait--;
            if (resp_wait == 0) begin
                mem_valid_i <= 1'b1;
                mem_data_i  <= build_line(resp_addr);
            end
        end
        if (take_q) begin
            resp_wait = 1 + int'(rand_next() % 4);
            resp_addr = take_addr;
            take_q    = 1'b0;
        end
        r = rand_next();
        mem_ready_i <= stall_mode ? r[3] : 1'b1;
        dec_ready_i <= stall_mode ? r[7] : 1'b1;
    end

    // ############################################################
    // Decode side checker
    // ############################################################

    always @(negedge clk_i) begin
        if (!reset_i) begin
            if (hold_q) begin
                assert (ic_valid_o) else begin
                    err_proto++;
                    $display("%s: ic_valid_o dropped before dec_ready_i", cur_test);
                end
                assert (ic_pc_o == held_pc) else begin
                    err_value++;
                    $display("ERR %s held pc exp=%h act=%h", cur_test, held_pc, ic_pc_o);
                end
                assert (ic_inst_o == held_inst) else begin
                    err_value++;
                    $display("ERR %s held inst exp=%h act=%h", cur_test, held_inst, ic_inst_o);
                end
            end
            // No new fetch taken while one is in flight
            if (flight_q && !(ic_valid_o && dec_ready_i)) begin
                assert (!ic_ready_o) else begin
                    err_value++;
                    $display("ERR %s ic_ready_o exp=0 act=%b", cur_test, ic_ready_o);
                end
            end
            if (ic_valid_o && !valid_q) begin
                valid_cyc = cycle;
            end
            if (ic_valid_o && dec_ready_i) begin
                assert (ic_pc_o == cur_pc) else begin
                    err_value++;
                    $display("ERR %s pc exp=%h act=%h", cur_test, cur_pc, ic_pc_o);
                end
                assert (ic_inst_o == ref_inst(cur_pc)) else begin
                    err_value++;
                    $display("ERR %s inst exp=%h act=%h", cur_test, ref_inst(cur_pc), ic_inst_o);
                end
                xfer_count++;
                flight_q = 1'b0;
            end
            if (fe_valid_i && ic_ready_o) begin
                flight_q = 1'b1;
            end
            hold_q    = ic_valid_o && !dec_ready_i;
            held_pc   = ic_pc_o;
            held_inst = ic_inst_o;
            valid_q   = ic_valid_o;
        end
    end

    // ############################################################
    // Stimulus
    // ############################################################

    task automatic run_fetch(input string name, input logic [pw-1:0] pc);
        logic miss;
        int idx, reqs_before, target;
        logic [pw-1:0] tag;
        idx = int'((pc >> lwb) % nl);
        tag = pc >> (lwb + ib);
        miss = !(res_valid[idx] && res_tag[idx] == tag);
        res_valid[idx] = 1'b1;
        res_tag[idx]   = tag;
        cur_test    = name;
        cur_pc      = pc;
        reqs_before = req_count;
        target      = xfer_count + 1;
        @(posedge clk_i);
        fe_valid_i <= 1'b1;
        fe_pc_i    <= pc;
        do @(negedge clk_i); while (!(fe_valid_i && ic_ready_o));
        accept_cyc = cycle;
        @(posedge clk_i);
        fe_valid_i <= 1'b0;
        wait (xfer_count == target);
        assert (req_count - reqs_before == (miss ? 1 : 0)) else begin
            err_value++;
            $display("ERR %s mem requests exp=%0d act=%0d", name, miss ? 1 : 0,
                     req_count - reqs_before);
        end
        if (!miss) begin
            assert (valid_cyc == accept_cyc + 1) else begin
                err_value++;
                $display("ERR %s hit latency exp=%0d act=%0d", name, 1, valid_cyc - accept_cyc);
            end
        end
    endtask

    task automatic pulse_flush();
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        for (int i = 0; i < nl; i++) begin
            res_valid[i] = 1'b0;
        end
    endtask

    initial begin
        logic [pw-1:0] pc;
        for (int i = 0; i < nl; i++) begin
            res_valid[i] = 1'b0;
            res_tag[i]   = '0;
        end
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        run_fetch("cold_miss", 32'h0000_1004);
        // PC counts instructions, so one line is four consecutive PCs
        for (int k = 0; k < 4; k++) begin
            run_fetch("resident_hit", 32'h0000_1004 + 32'(k));
        end
        // Same index, other tag, then back to the evicted line
        run_fetch("conflict", 32'h0000_2004);
        run_fetch("conflict_return", 32'h0000_1006);
        run_fetch("conflict_evicted", 32'h0000_2007);
        run_fetch("flush_fill", 32'h0000_3010);
        pulse_flush();
        run_fetch("flush_miss", 32'h0000_3011);
        run_fetch("flush_refill_hit", 32'h0000_3012);
        stall_mode = 1'b1;
        for (int i = 0; i < 40; i++) begin
            pc = 32'(rand_next()) & 32'h0000_00ff;
            run_fetch("random_stall", pc);
        end
        $display("Errors: value %0d, protocol %0d", err_value, err_proto);
        if (err_value + err_proto == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : tb_instruction_cache
